/* source/bitops_pkg.sv */
package bitops_pkg;

    ////////////////////////////////////////////////////////////////////
    // operand
    ////////////////////////////////////////////////////////////////////

    // default operand width of the top level
    localparam int unsigned OPER_W = 64;
    // encoder index width for the default operand
    // modules derive their own from WIDTH
    localparam int unsigned IDX_W = $clog2(OPER_W);

    // operation code
    typedef enum logic [1:0] {
        OP_NEG    = 2'd0,  // two's complement
        OP_ONEHOT = 2'd1,  // lowest set bit only
        OP_ENCODE = 2'd2,  // {vld, idx} of lowest set bit
        OP_PASS   = 2'd3   // operand unchanged
    } op_e;

    ////////////////////////////////////////////////////////////////////
    // AXI4-Lite register map
    ////////////////////////////////////////////////////////////////////

    localparam int unsigned AXIL_AW = 4;

    // byte offsets
    localparam logic [AXIL_AW-1:0] REG_CTRL     = 4'h0;
    localparam logic [AXIL_AW-1:0] REG_RES_LO   = 4'h4;
    localparam logic [AXIL_AW-1:0] REG_RES_HI   = 4'h8;
    localparam logic [AXIL_AW-1:0] REG_LOAD_CNT = 4'hC;

    // response code
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

endpackage: bitops_pkg

/* source/bitop_if.sv */
`timescale 1ns/1ps

interface bitop_if #(
    parameter int unsigned WIDTH = bitops_pkg::OPER_W
);

    import bitops_pkg::*;

    // selected operation, from the register block
    op_e              op;
    // registered result and its strobe, from the unit
    logic [WIDTH-1:0] result;
    logic             result_vld;
    // clears the unit's pld tracking around reset
    logic             clr_cnt;

    // register block side
    modport ctrl (
        output op,
        output clr_cnt,
        input  result,
        input  result_vld
    );

    // operation unit side
    modport unit (
        input  op,
        input  clr_cnt,
        output result,
        output result_vld
    );

endinterface: bitop_if

/* source/shift_placeholder.sv */
`timescale 1ns/1ps

module shift_placeholder #(
    parameter int unsigned WIDTH = bitops_pkg::OPER_W
)(
    // system signals
    input  logic             clk,
    input  logic             rst_n_i,
    // control
    input  logic             pld_i,
    // data inputs
    input  logic             ser_i,
    input  logic [WIDTH-1:0] par_i,
    // data outputs
    output logic [WIDTH-1:0] par_o,
    output logic             ser_o
);

    ////////////////////////////////////////////////////////////////////
    // shift and capture registers
    ////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] shr;
    logic [WIDTH-1:0] shr_nxt;

    // next shift value, ser_i enters at bit 0
    assign shr_nxt = {shr[WIDTH-2:0], ser_i};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            shr   <= '0;
            par_o <= '0;
        end else if (pld_i) begin
            // capture includes the bit arriving now
            par_o <= shr_nxt;
            // serializer side takes the new word
            shr   <= par_i;
        end else begin
            shr   <= shr_nxt;
        end
    end

    // msb first on the serial output
    assign ser_o = shr[WIDTH-1];

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    // back to back loads would lose a whole word
    a_pld_spacing: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pld_i |=> !pld_i
    ) else $error("pld_i high in two consecutive cycles");

endmodule: shift_placeholder

/* source/bitop_unit.sv */
`timescale 1ns/1ps

module bitop_unit #(
    parameter int unsigned WIDTH = bitops_pkg::OPER_W
)(
    // system signals
    input  logic             clk,
    input  logic             rst_n_i,
    // control
    input  logic             pld_i,
    // operand from the input shift register
    input  logic [WIDTH-1:0] operand_i,
    // op in, result out
    bitop_if.unit            bus
);

    import bitops_pkg::*;

    // encoder index width for this operand
    localparam int unsigned IDX_W = $clog2(WIDTH);

    ////////////////////////////////////////////////////////////////////
    // operand freshness
    ////////////////////////////////////////////////////////////////////

    // operand_i settles one cycle after the load
    logic pld_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || bus.clr_cnt) begin
            pld_q <= 1'b0;
        end else begin
            pld_q <= pld_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] neg;
    logic [WIDTH-1:0] onehot;
    logic [IDX_W-1:0] enc_idx;
    logic             enc_vld;
    logic [WIDTH-1:0] enc_res;
    logic [WIDTH-1:0] res_nxt;

    // two's complement
    assign neg    = -operand_i;
    // x & -x keeps the lowest set bit
    assign onehot = operand_i & neg;

    // at most one bit of onehot is set
    // so OR-ing the indexes gives the lowest set bit
    always_comb begin
        enc_idx = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (onehot[i]) begin
                enc_idx = enc_idx | IDX_W'(i);
            end
        end
    end

    // zero operand has no set bit
    assign enc_vld = |operand_i;

    // flag just above the index, rest zero
    always_comb begin
        enc_res             = '0;
        enc_res[IDX_W-1:0]  = enc_idx;
        enc_res[IDX_W]      = enc_vld;
    end

    // op as sampled at the result edge
    always_comb begin
        case (bus.op)
            OP_NEG:    res_nxt = neg;
            OP_ONEHOT: res_nxt = onehot;
            OP_ENCODE: res_nxt = enc_res;
            default:   res_nxt = operand_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // result register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bus.result     <= '0;
            bus.result_vld <= 1'b0;
        end else begin
            bus.result_vld <= pld_q;
            if (pld_q) begin
                bus.result <= res_nxt;
            end
        end
    end

    // one strobe per loaded operand
    a_vld_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        bus.result_vld |=> !bus.result_vld
    ) else $error("result_vld high for two cycles");

endmodule: bitop_unit

/* source/bitop_regs.sv */
`timescale 1ns/1ps

module bitop_regs #(
    parameter int unsigned WIDTH = bitops_pkg::OPER_W
)(
    // system signals
    input  logic                            clk,
    input  logic                            rst_n_i,
    // operation unit
    bitop_if.ctrl                           bus,
    // write address
    input  logic [bitops_pkg::AXIL_AW-1:0]  s_axil_awaddr_i,
    input  logic                            s_axil_awvalid_i,
    output logic                            s_axil_awready_o,
    // write data
    input  logic [31:0]                     s_axil_wdata_i,
    input  logic [3:0]                      s_axil_wstrb_i,
    input  logic                            s_axil_wvalid_i,
    output logic                            s_axil_wready_o,
    // write response
    output logic [1:0]                      s_axil_bresp_o,
    output logic                            s_axil_bvalid_o,
    input  logic                            s_axil_bready_i,
    // read address
    input  logic [bitops_pkg::AXIL_AW-1:0]  s_axil_araddr_i,
    input  logic                            s_axil_arvalid_i,
    output logic                            s_axil_arready_o,
    // read data
    output logic [31:0]                     s_axil_rdata_o,
    output logic [1:0]                      s_axil_rresp_o,
    output logic                            s_axil_rvalid_o,
    input  logic                            s_axil_rready_i
);

    import bitops_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////////////

    logic wr_en;
    logic rd_en;

    // transfer happens while the ready pulse is up
    assign wr_en = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_en = s_axil_arready_o && s_axil_arvalid_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
        end else begin
            // address and data accepted together, one cycle only
            s_axil_awready_o <= s_axil_awvalid_i && s_axil_wvalid_i
                                && !s_axil_bvalid_o && !s_axil_awready_o;
            s_axil_wready_o  <= s_axil_awvalid_i && s_axil_wvalid_i
                                && !s_axil_bvalid_o && !s_axil_awready_o;
            // response held until bready
            if (wr_en) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            // no new read while data is pending
            s_axil_arready_o <= s_axil_arvalid_i && !s_axil_rvalid_o
                                && !s_axil_arready_o;
            if (rd_en) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    // every access is OKAY, unmapped ones too
    assign s_axil_bresp_o = RESP_OKAY;
    assign s_axil_rresp_o = RESP_OKAY;

    ////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////

    op_e              op_q;
    logic [WIDTH-1:0] res_q;
    logic [63:0]      res_ext;
    logic [31:0]      load_cnt;
    logic [31:0]      rd_word;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_q        <= OP_PASS;
            res_q       <= '0;
            load_cnt    <= '0;
            bus.clr_cnt <= 1'b1;
        end else begin
            bus.clr_cnt <= 1'b0;
            // only CTRL is writable, low byte lane
            if (wr_en && s_axil_awaddr_i == REG_CTRL && s_axil_wstrb_i[0]) begin
                op_q <= op_e'(s_axil_wdata_i[1:0]);
            end
            if (bus.result_vld) begin
                res_q    <= bus.result;
                load_cnt <= load_cnt + 32'd1;
            end
        end
    end

    assign bus.op  = op_q;
    assign res_ext = 64'(res_q);

    // read mux, unmapped reads as zero
    always_comb begin
        case (s_axil_araddr_i)
            REG_CTRL:     rd_word = {30'd0, op_q};
            REG_RES_LO:   rd_word = res_ext[31:0];
            REG_RES_HI:   rd_word = res_ext[63:32];
            REG_LOAD_CNT: rd_word = load_cnt;
            default:      rd_word = '0;
        endcase
    end

    // read data payload, loaded at the accept edge
    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_axil_rdata_o <= rd_word;
        end
    end

    // responses may not drop before the master takes them
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o
    ) else $error("bvalid dropped without bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o
    ) else $error("rvalid dropped without rready");

endmodule: bitop_regs

/* source/bitops_top.sv */
`timescale 1ns/1ps

module bitops_top #(
    parameter int unsigned WIDTH = bitops_pkg::OPER_W
)(
    // system signals
    input  logic                            clk,
    input  logic                            rst_n_i,
    // serial operand in, result out
    input  logic                            ser_i,
    input  logic                            pld_i,
    output logic                            ser_o,
    // AXI4-Lite slave
    input  logic [bitops_pkg::AXIL_AW-1:0]  s_axil_awaddr_i,
    input  logic                            s_axil_awvalid_i,
    output logic                            s_axil_awready_o,
    input  logic [31:0]                     s_axil_wdata_i,
    input  logic [3:0]                      s_axil_wstrb_i,
    input  logic                            s_axil_wvalid_i,
    output logic                            s_axil_wready_o,
    output logic [1:0]                      s_axil_bresp_o,
    output logic                            s_axil_bvalid_o,
    input  logic                            s_axil_bready_i,
    input  logic [bitops_pkg::AXIL_AW-1:0]  s_axil_araddr_i,
    input  logic                            s_axil_arvalid_i,
    output logic                            s_axil_arready_o,
    output logic [31:0]                     s_axil_rdata_o,
    output logic [1:0]                      s_axil_rresp_o,
    output logic                            s_axil_rvalid_o,
    input  logic                            s_axil_rready_i
);

    ////////////////////////////////////////////////////////////////////
    // serial datapath
    ////////////////////////////////////////////////////////////////////

    bitop_if #(.WIDTH(WIDTH)) bus ();

    // deserialized operand
    logic [WIDTH-1:0] operand;

    // input side, serial out unused
    shift_placeholder #(.WIDTH(WIDTH)) u_shift_in (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .pld_i   (pld_i),
        .ser_i   (ser_i),
        .par_i   ('0),
        .par_o   (operand),
        .ser_o   ()
    );

    bitop_unit #(.WIDTH(WIDTH)) u_unit (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pld_i     (pld_i),
        .operand_i (operand),
        .bus       (bus.unit)
    );

    // output side, result loaded on the next pld
    shift_placeholder #(.WIDTH(WIDTH)) u_shift_out (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .pld_i   (pld_i),
        .ser_i   (1'b0),
        .par_i   (bus.result),
        .par_o   (),
        .ser_o   (ser_o)
    );

    ////////////////////////////////////////////////////////////////////
    // register block
    ////////////////////////////////////////////////////////////////////

    bitop_regs #(.WIDTH(WIDTH)) u_regs (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .bus              (bus.ctrl),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i)
    );

endmodule: bitops_top

/* tb/tb_bitops.sv */
`timescale 1ns/1ps

module tb_bitops;

    import bitops_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////

    localparam int    WIDTH           = 64;
    localparam string CASE_FILE       = "tb/bitops_cases.txt";
    // one serial bit per clock, 10 ns period
    localparam int    CLK_HALF        = 5;
    localparam int    CYCLES_PER_CASE = 200;
    localparam int    TIMEOUT_MARGIN  = 500;
    // no register decodes this offset
    localparam logic [3:0] UNMAPPED   = 4'h6;

    // DUT signals
    logic        clk;
    logic        rst_n;
    logic        ser_in;
    logic        pld;
    logic        ser_out;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // bookkeeping
    int          errors;
    int          checks;
    int          plds_sent;
    int          cycles;
    int          cycle_limit;
    int          n_cases;
    logic [1:0]  case_op [$];
    logic [63:0] case_operand [$];
    logic [63:0] case_expect [$];
    // words seen on ser_out, one per load
    logic [63:0] ser_words [$];
    int          mon_cnt;
    logic [63:0] mon_bits;
    int          mon_plds;

    // file parsing and main loop
    int          fd;
    string       line;
    int          c_op;
    logic [63:0] c_operand;
    logic [63:0] c_expect;
    logic [31:0] rd;
    logic [1:0]  resp;
    logic [63:0] exp64;

    bitops_top #(.WIDTH(WIDTH)) i_bitops_top (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .ser_i            (ser_in),
        .pld_i            (pld),
        .ser_o            (ser_out),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // bus and serial tasks
    ////////////////////////////////////////////////////////////////////

    task automatic axil_write(
        input  logic [3:0]  addr,
        input  logic [31:0] data,
        output logic [1:0]  wr_resp
    );
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        // awready seen here, accepted at the next rising edge
        @(negedge clk);
        while (!awready) @(negedge clk);
        // data channel taken in the same cycle as the address
        checks++;
        if (wready !== 1'b1) begin
            errors++;
            $display("Error: wready with awready expected 1 actual %b", wready);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        wr_resp = bresp;
    endtask

    task automatic axil_read(
        input  logic [3:0]  addr,
        output logic [31:0] data,
        output logic [1:0]  rd_resp
    );
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data    = rdata;
        rd_resp = rresp;
    endtask

    // msb first, load strobe on the last bit
    task automatic send_operand(input logic [63:0] operand);
        for (int b = WIDTH - 1; b >= 0; b--) begin
            @(negedge clk);
            ser_in = operand[b];
            pld    = (b == 0);
        end
        @(negedge clk);
        ser_in = 1'b0;
        pld    = 1'b0;
        plds_sent++;
    endtask

    // CTRL, RES_LO, RES_HI, LOAD_CNT, only CTRL nonzero
    task automatic check_regs(input string label, input logic [31:0] ctrl_exp);
        logic [31:0] data;
        logic [31:0] want;
        logic [1:0]  r_resp;
        for (int r = 0; r < 4; r++) begin
            want = (r == 0) ? ctrl_exp : 32'd0;
            axil_read(4'(4 * r), data, r_resp);
            checks++;
            if (data !== want) begin
                errors++;
                $display("Error: %s reg 0x%h expected %h actual %h",
                         label, 4'(4 * r), want, data);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // serial output monitor
    ////////////////////////////////////////////////////////////////////

    // ser_out and pld both settle before the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            mon_cnt  = WIDTH;
            mon_bits = '0;
            mon_plds = 0;
        end else begin
            // gather the word loaded at the last pld edge
            if (mon_cnt < WIDTH) begin
                mon_bits = {mon_bits[WIDTH-2:0], ser_out};
                mon_cnt++;
                if (mon_cnt == WIDTH) begin
                    ser_words.push_back(mon_bits);
                end
            end
            // nothing loaded yet, output idle
            if (mon_plds == 0) begin
                checks++;
                if (ser_out !== 1'b0) begin
                    errors++;
                    $display("Error: idle ser_o expected 0 actual %b", ser_out);
                end
            end
            if (pld) begin
                mon_cnt  = 0;
                mon_bits = '0;
                mon_plds++;
            end
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        ser_in    = 1'b0;
        pld       = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        errors    = 0;
        checks    = 0;
        plds_sent = 0;

        // op decimal, operand and expected hex, comment lines skipped
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open case file %s", CASE_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %h %h", c_op, c_operand, c_expect) == 3) begin
                    case_op.push_back(c_op[1:0]);
                    case_operand.push_back(c_operand);
                    case_expect.push_back(c_expect);
                end
            end
            $fclose(fd);
        end
        n_cases     = case_op.size();
        cycle_limit = n_cases * CYCLES_PER_CASE + TIMEOUT_MARGIN;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        check_regs("reset", 32'(OP_PASS));

        // every op code reads back
        for (int o = 0; o < 4; o++) begin
            axil_write(REG_CTRL, 32'(o), resp);
            axil_read(REG_CTRL, rd, resp);
            checks++;
            if (rd !== 32'(o)) begin
                errors++;
                $display("Error: CTRL op %0d expected %h actual %h", o, 32'(o), rd);
            end
        end

        // unmapped write is dropped, unmapped read is zero, both OKAY
        axil_write(REG_CTRL, 32'(OP_ENCODE), resp);
        axil_write(UNMAPPED, 32'hffff_ffff, resp);
        checks++;
        if (resp !== 2'(RESP_OKAY)) begin
            errors++;
            $display("Error: unmapped bresp expected %h actual %h", 2'(RESP_OKAY), resp);
        end
        axil_read(UNMAPPED, rd, resp);
        checks += 2;
        if (rd !== 32'd0) begin
            errors++;
            $display("Error: unmapped rdata expected %h actual %h", 32'd0, rd);
        end
        if (resp !== 2'(RESP_OKAY)) begin
            errors++;
            $display("Error: unmapped rresp expected %h actual %h", 2'(RESP_OKAY), resp);
        end
        check_regs("after unmapped write", 32'(OP_ENCODE));

        for (int i = 0; i < n_cases; i++) begin
            axil_write(REG_CTRL, 32'(case_op[i]), resp);
            send_operand(case_operand[i]);
            // result lands in RES two cycles after pld
            repeat (3) @(negedge clk);
            axil_read(REG_RES_LO, rd, resp);
            checks++;
            if (rd !== case_expect[i][31:0]) begin
                errors++;
                $display("Error: case %0d RES_LO expected %h actual %h",
                         i, case_expect[i][31:0], rd);
            end
            axil_read(REG_RES_HI, rd, resp);
            checks++;
            if (rd !== case_expect[i][63:32]) begin
                errors++;
                $display("Error: case %0d RES_HI expected %h actual %h",
                         i, case_expect[i][63:32], rd);
            end
        end

        // dummy pushes the last result into the output register
        send_operand(64'd0);
        while (ser_words.size() < n_cases + 1) @(negedge clk);

        // word 0 is the reset result, word i+1 belongs to case i
        for (int w = 0; w <= n_cases; w++) begin
            if (w == 0) begin
                exp64 = 64'd0;
            end else begin
                exp64 = case_expect[w-1];
            end
            checks++;
            if (ser_words[w] !== exp64) begin
                errors++;
                $display("Error: serial word %0d expected %h actual %h",
                         w, exp64, ser_words[w]);
            end
        end

        axil_read(REG_LOAD_CNT, rd, resp);
        checks++;
        if (rd !== 32'(plds_sent)) begin
            errors++;
            $display("Error: LOAD_CNT expected %h actual %h", 32'(plds_sent), rd);
        end

        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule: tb_bitops

/* tb/bitops_cases.txt */
// op (0 neg, 1 onehot, 2 encode, 3 pass), operand hex, expected hex
// encode result is {valid at bit 6, index of lowest set bit}
0 0000000000000000 0000000000000000
0 0000000000000001 ffffffffffffffff
0 8000000000000000 8000000000000000
0 ffffffffffffffff 0000000000000001
0 0123456789abcdef fedcba9876543211
0 00000000fffff000 ffffffff00001000
1 0000000000000000 0000000000000000
1 0000000000000001 0000000000000001
1 8000000000000000 8000000000000000
1 ffffffffffffffff 0000000000000001
1 0123456789abcdef 0000000000000001
1 0123456789abcde0 0000000000000020
1 00000000fffff000 0000000000001000
1 a5a5000000000000 0001000000000000
2 0000000000000000 0000000000000000
2 0000000000000001 0000000000000040
2 8000000000000000 000000000000007f
2 ffffffffffffffff 0000000000000040
2 0000000000000100 0000000000000048
2 00000000fffff000 000000000000004c
2 0100000000000000 0000000000000078
2 a5a5000000000000 0000000000000070
2 0000000100000000 0000000000000060
3 0000000000000000 0000000000000000
3 0000000000000001 0000000000000001
3 8000000000000000 8000000000000000
3 ffffffffffffffff ffffffffffffffff
3 0123456789abcdef 0123456789abcdef
3 deadbeefcafef00d deadbeefcafef00d

/* filelist.f */
source/bitops_pkg.sv
source/bitop_if.sv
source/shift_placeholder.sv
source/bitop_unit.sv
source/bitop_regs.sv
source/bitops_top.sv
tb/tb_bitops.sv

/* Makefile */
# bitops testbench on Verilator

TOP := tb_bitops

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP) -f filelist.f
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
